// File: video_pkg.sv
`default_nettype none

package video_pkg;

	// fetch group and line index widths
	localparam int GROUP_W = 4;
	localparam int LINE_W = 8;

	localparam int VRAM_AW = 16; // vram word address

	// fetch period length in pixels
	localparam int PERIOD_SHORT = 16;
	localparam int PERIOD_LONG = 32;
	localparam int PIX_CNT_W = 6; // holds PERIOD_LONG

	// display modes, held steady between resets
	typedef enum logic [2:0] {
		mode_zx      = 3'd0,
		mode_p_16c   = 3'd1,
		mode_p_hmclr = 3'd2,
		mode_a_hmclr = 3'd3,
		mode_a_16c   = 3'd4,
		mode_a_text  = 3'd5
	} video_mode_e;

	// one pulse each per 4-clock character phase
	typedef struct packed {
		logic cbeg;      // phase 0
		logic post_cbeg; // phase 1
		logic pre_cend;  // phase 1
		logic cend;      // phase 2
	} pix_strobe_t;

	// sync to fetch
	typedef struct packed {
		logic               fetch_sync; // start of fetch period, with cbeg
		logic [GROUP_W-1:0] group_idx;  // group within line
		logic [LINE_W-1:0]  line;
	} fetch_ctl_t;

endpackage

`default_nettype wire

// File: video_sync.sv
`default_nettype none

module video_sync #(
	parameter int line_groups = 16,
	parameter int frame_lines = 256
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire video_pkg::video_mode_e mode,
	input  wire                      pixf_14,
	output video_pkg::pix_strobe_t   strobes,
	output video_pkg::fetch_ctl_t    fetch_ctl,
	output logic                     int_start,
	output logic [2:0]               typos
);
	import video_pkg::*;

	logic [1:0]           phase;   // character phase
	logic [PIX_CNT_W-1:0] pix_cnt; // pixels since fetch_sync
	logic [PIX_CNT_W-1:0] period_len;
	logic                 started; // first fetch_sync seen
	logic                 pix_en;
	logic                 sync_now;
	logic [GROUP_W-1:0]   group_q; // index of the period starting at next sync
	logic [LINE_W-1:0]    line_q;
	logic [2:0]           row_q;   // text row of the current period

	always_ff @(posedge clk)
	begin
		if (reset)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	assign strobes.cbeg = (phase == 2'd0);
	assign strobes.post_cbeg = (phase == 2'd1);
	assign strobes.pre_cend = (phase == 2'd1);
	assign strobes.cend = (phase == 2'd2);

	assign pix_en = strobes.cend | (pixf_14 & strobes.post_cbeg);

	// wide modes fetch every 32 pixels
	assign period_len = (mode == mode_a_hmclr || mode == mode_a_text) ?
		PIX_CNT_W'(PERIOD_LONG) : PIX_CNT_W'(PERIOD_SHORT);

	assign sync_now = strobes.cbeg & (~started | (pix_cnt == period_len));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			started <= 1'b0;
			pix_cnt <= '0;
			group_q <= '0;
			line_q <= '0;
			row_q <= '0;
		end
		else if (sync_now)
		begin
			started <= 1'b1;
			pix_cnt <= '0;
			row_q <= line_q[2:0];
			if (group_q == GROUP_W'(line_groups - 1))
			begin
				group_q <= '0;
				if (line_q == LINE_W'(frame_lines - 1))
					line_q <= '0;
				else
					line_q <= line_q + 1'b1;
			end
			else
				group_q <= group_q + 1'b1;
		end
		else if (pix_en)
			pix_cnt <= pix_cnt + 1'b1;
	end

	assign fetch_ctl.fetch_sync = sync_now;
	assign fetch_ctl.group_idx = group_q;
	assign fetch_ctl.line = line_q;

	assign int_start = sync_now & (group_q == '0) & (line_q == '0); // frame start
	assign typos = row_q;

endmodule

`default_nettype wire

// File: video_fetch.sv
`default_nettype none

module video_fetch (
	input  wire                           clk,
	input  wire                           reset,
	input  wire video_pkg::fetch_ctl_t    fetch_ctl,
	output logic                          vram_rd,
	output logic [video_pkg::VRAM_AW-1:0] vram_addr,
	input  wire [15:0]                    vram_data,
	output logic [63:0]                   pic_bits
);
	import video_pkg::*;

	localparam int BASE_W = LINE_W + GROUP_W;

	logic [BASE_W-1:0] base;   // {line, group} of the group being read
	logic [1:0]        word;   // word being requested
	logic              busy;
	logic              rd_d;   // data valid this cycle
	logic [1:0]        word_d;
	logic [63:0]       hold;   // group under assembly

	// four reads on consecutive clocks after fetch_sync
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			word <= 2'd0;
		end
		else if (fetch_ctl.fetch_sync)
		begin
			busy <= 1'b1;
			word <= 2'd0;
		end
		else if (busy)
		begin
			word <= word + 2'd1;
			if (word == 2'd3)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch_ctl.fetch_sync)
			base <= {fetch_ctl.line, fetch_ctl.group_idx};
	end

	assign vram_rd = busy;
	assign vram_addr = {{(VRAM_AW - BASE_W - 2){1'b0}}, base, word};

	// vram answers one clock after each read
	always_ff @(posedge clk)
	begin
		if (reset)
			rd_d <= 1'b0;
		else
			rd_d <= vram_rd;
		word_d <= word;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			hold <= '0;
		else if (rd_d)
			hold[{word_d, 4'b0000} +: 16] <= vram_data; // word w into bits 16w+15:16w
	end

	// display of a group runs one period behind its fetch
	always_ff @(posedge clk)
	begin
		if (reset)
			pic_bits <= '0;
		else if (fetch_ctl.fetch_sync)
			pic_bits <= hold;
	end

endmodule

`default_nettype wire

// File: video_render.sv
`default_nettype none

module video_render (
	input  wire                         clk,
	input  wire                         reset,
	input  wire video_pkg::pix_strobe_t strobes,
	input  wire                         fetch_sync,
	input  wire                         int_start,
	input  wire [2:0]                   typos,
	input  wire video_pkg::video_mode_e mode,
	input  wire                         pixf_14,
	input  wire [63:0]                  pic_bits,
	output logic [3:0]                  pixels,
	output logic                        pix_stb
);
	import video_pkg::*;

	logic       modes_16c;
	logic       modes_zxattr;
	logic       mode_text;
	logic       ena_pix;
	logic [4:0] flash_ctr;
	logic       flash;
	logic [2:0] pnum;      // pixel within byte
	logic [2:0] padd;
	logic [1:0] gnum;      // byte pair within group
	logic [1:0] gadd;
	logic       ginc;
	logic [7:0] pixbyte;
	logic [7:0] attrbyte;
	logic [7:0] symbyte;   // glyph row from font rom
	logic       pixbit;
	logic [3:0] ink;
	logic [3:0] paper;
	logic [3:0] apix;
	logic [3:0] c16pix;
	logic       rom_en;

	assign modes_16c = (mode == mode_p_16c) || (mode == mode_a_16c);
	assign modes_zxattr = (mode == mode_zx) || (mode == mode_p_hmclr);
	assign mode_text = (mode == mode_a_text);

	assign ena_pix = strobes.cend | (pixf_14 & strobes.post_cbeg);

	always_ff @(posedge clk)
	begin
		if (reset)
			flash_ctr <= '0;
		else if (int_start)
			flash_ctr <= flash_ctr + 5'd1;
	end
	assign flash = flash_ctr[4]; // toggles every 16 frames

	// 16c packs two pixels per byte, zx attr skips the odd pairs
	assign {ginc, padd} = {1'b0, pnum} + {2'b00, modes_16c, ~modes_16c};
	assign gadd = gnum + ({modes_zxattr, ~modes_zxattr} & {2{ginc}});

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pnum <= 3'd0;
			gnum <= 2'd0;
		end
		else if (fetch_sync)
		begin
			pnum <= 3'd0;
			gnum <= 2'd0;
		end
		else if (ena_pix)
		begin
			pnum <= padd;
			gnum <= gadd;
		end
	end

	// interleaved byte order of the group
	assign pixbyte = pic_bits[{gnum[0], 1'b0, gnum[1], 3'b000} +: 8];
	assign attrbyte = pic_bits[{gnum[0], 1'b1, gnum[1], 3'b000} +: 8];

	always_comb
	begin
		case (pnum[2:1])
			2'd0: c16pix = {attrbyte[6], attrbyte[2:0]};
			2'd1: c16pix = {attrbyte[7], attrbyte[5:3]};
			2'd2: c16pix = {pixbyte[6], pixbyte[2:0]};
			default: c16pix = {pixbyte[7], pixbyte[5:3]};
		endcase
	end

	assign pixbit = mode_text ? symbyte[~pnum] : pixbyte[~pnum]; // msb first

	assign paper = {(modes_zxattr ? attrbyte[6] : attrbyte[7]), attrbyte[5:3]};
	assign ink = {attrbyte[6], attrbyte[2:0]};
	assign apix = (pixbit ^ (modes_zxattr & flash & attrbyte[7])) ? ink : paper;

	always_ff @(posedge clk)
	begin
		if (reset)
			pix_stb <= 1'b0;
		else
			pix_stb <= ena_pix;
	end

	always_ff @(posedge clk)
	begin
		if (ena_pix)
			pixels <= modes_16c ? c16pix : apix;
	end

	// glyph for the next cell is looked up at the end of this one
	assign rom_en = ena_pix & ginc;

	video_fontrom u_video_fontrom (
		.clk  (clk),
		.en   (rom_en),
		.addr ({pixbyte, typos}),
		.q    (symbyte)
	);

endmodule

`default_nettype wire

// File: video_fontrom.sv
`default_nettype none

module video_fontrom (
	input  wire         clk,
	input  wire         en,
	input  wire  [10:0] addr, // {code, row}
	output logic [7:0]  q
);

	logic [7:0] mem [0:2047];

	// row r of glyph c is c rotated left by r
	initial
	begin
		logic [15:0] dbl;
		for (int i = 0; i < 2048; i++)
		begin
			dbl = {i[10:3], i[10:3]} << i[2:0];
			mem[i] = dbl[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (en)
			q <= mem[addr];
	end

endmodule

`default_nettype wire

// File: video_top.sv
`default_nettype none

module video_top #(
	parameter int line_groups = 16, // fetch groups per line
	parameter int frame_lines = 256
) (
	input  wire                           clk,
	input  wire                           reset,
	input  wire video_pkg::video_mode_e   mode,
	input  wire                           pixf_14,
	output logic                          vram_rd,
	output logic [video_pkg::VRAM_AW-1:0] vram_addr,
	input  wire [15:0]                    vram_data,
	output logic [3:0]                    pixels,
	output logic                          pix_stb,
	output logic                          int_start
);
	import video_pkg::*;

	pix_strobe_t strobes;
	fetch_ctl_t  fetch_ctl;
	logic [63:0] pic_bits; // group on display
	logic [2:0]  typos;

	video_sync #(
		.line_groups (line_groups),
		.frame_lines (frame_lines)
	) u_video_sync (
		.clk       (clk),
		.reset     (reset),
		.mode      (mode),
		.pixf_14   (pixf_14),
		.strobes   (strobes),
		.fetch_ctl (fetch_ctl),
		.int_start (int_start),
		.typos     (typos)
	);

	video_fetch u_video_fetch (
		.clk       (clk),
		.reset     (reset),
		.fetch_ctl (fetch_ctl),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.pic_bits  (pic_bits)
	);

	video_render u_video_render (
		.clk        (clk),
		.reset      (reset),
		.strobes    (strobes),
		.fetch_sync (fetch_ctl.fetch_sync),
		.int_start  (int_start),
		.typos      (typos),
		.mode       (mode),
		.pixf_14    (pixf_14),
		.pic_bits   (pic_bits),
		.pixels     (pixels),
		.pix_stb    (pix_stb)
	);

endmodule

`default_nettype wire

// File: tb_video.sv
`default_nettype none

module tb_video;
	timeunit 1ns;
	timeprecision 100ps;
	import video_pkg::*;

	localparam int groups = 4;       // fetch groups per line
	localparam int lines = 8;        // lines per frame
	localparam int frame_periods = groups * lines;
	localparam int long_frames = 18; // runs past 16 frames so flash shows
	localparam int short_frames = 2;
	// long runs for zx at 7 and 14 MHz and a_hmclr, short ones for the other modes
	localparam int run_cycles = frame_periods *
		(long_frames * (64 + 32 + 128) + short_frames * (64 + 64 + 128));
	localparam int timeout_limit = (run_cycles + 6 * 8) * 3 / 2;

	logic              clk = 1'b0;
	logic              reset = 1'b1;
	video_mode_e       mode = mode_zx;
	logic              pixf_14 = 1'b0;
	logic [15:0]       vram_data = 16'h0000;
	logic              vram_rd;
	logic [VRAM_AW-1:0] vram_addr;
	logic [3:0]        pixels;
	logic              pix_stb;
	logic              int_start;

	logic [15:0]        vram [0:65535];
	logic               rd_seen = 1'b0;
	logic [VRAM_AW-1:0] addr_seen = '0;
	logic               active = 1'b0; // checks run only outside reset
	int                 cycles = 0;
	int                 cyc;           // cycles since reset release
	int                 pix_k;         // pixels seen since reset release
	int                 reads_in_period;
	int                 stb_in_frame;
	int                 starts_seen;
	logic [7:0]         glyph;         // glyph row held by the font rom
	logic               store_seq = 1'b0;
	logic               compare_seq = 1'b0;
	logic [3:0]         zx_seq [$];    // pixels of the first zx run

	video_top #(
		.line_groups (groups),
		.frame_lines (lines)
	) u_video_top (
		.clk       (clk),
		.reset     (reset),
		.mode      (mode),
		.pixf_14   (pixf_14),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.pixels    (pixels),
		.pix_stb   (pix_stb),
		.int_start (int_start)
	);

	always #20 clk = ~clk;

	// vram answers each read one clock later
	always @(negedge clk)
	begin
		rd_seen <= vram_rd;
		addr_seen <= vram_addr;
	end

	always @(posedge clk)
	begin
		#2;
		if (rd_seen)
			vram_data = vram[addr_seen];
	end

	task automatic stop_with_fail(input string why);
		$display("RESULT: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp == act)
		else
		begin
			$display("Fail %s: expected %0h, got %0h", name, exp, act);
			stop_with_fail("output mismatch");
		end
	endtask

	function automatic int period_pixels();
		return (mode == mode_a_hmclr || mode == mode_a_text) ? 32 : 16;
	endfunction

	function automatic int period_clocks();
		return pixf_14 ? 2 * period_pixels() : 4 * period_pixels(); // 2 or 1 pixels per phase
	endfunction

	// word w of fetch period n
	function automatic logic [VRAM_AW-1:0] fetch_addr(input int n, input int w);
		int line;
		int grp;
		line = (n / groups) % lines;
		grp = n % groups;
		return VRAM_AW'({LINE_W'(line), GROUP_W'(grp), 2'(w)});
	endfunction

	function automatic logic [63:0] group_data(input int n);
		logic [63:0] d;
		d = '0;
		if (n >= 0)
			for (int w = 0; w < 4; w++)
				d[16 * w +: 16] = vram[fetch_addr(n, w)];
		return d;
	endfunction

	function automatic logic flash_on(input int p);
		return ((p / frame_periods + 1) % 32) >= 16; // frames counted from the first one
	endfunction

	function automatic int text_row(input int p);
		return ((p / groups) % lines) % 8;
	endfunction

	function automatic logic [7:0] rotate_left(input logic [7:0] v, input int r);
		logic [7:0] x;
		x = v;
		for (int j = 0; j < r; j++)
			x = {x[6:0], x[7]};
		return x;
	endfunction

	// pixel k after reset, shown from the group fetched one period earlier
	task automatic predict_pixel(input int k, output logic [3:0] px, output logic [7:0] code);
		int         len;
		int         p;
		int         i;
		int         gn;
		logic [63:0] d;
		logic [7:0] pb;
		logic [7:0] ab;
		logic [7:0] src;
		logic       dot;
		logic       zxa;
		logic       c16;
		len = period_pixels();
		p = k / len;
		i = k % len;
		d = group_data(p - 1);
		zxa = (mode == mode_zx) || (mode == mode_p_hmclr);
		c16 = (mode == mode_p_16c) || (mode == mode_a_16c);
		if (c16)
			gn = (i / 4) % 4;       // four nibbles per byte pair
		else if (zxa)
			gn = (2 * (i / 8)) % 4; // odd pairs skipped
		else
			gn = (i / 8) % 4;
		pb = d[8 * (4 * (gn % 2) + gn / 2) +: 8];     // pairs sit at bytes 0, 4, 1, 5
		ab = d[8 * (4 * (gn % 2) + gn / 2 + 2) +: 8]; // attribute two bytes above
		code = pb;
		if (c16)
		begin
			case (i % 4)
				0: px = {ab[6], ab[2:0]};
				1: px = {ab[7], ab[5:3]};
				2: px = {pb[6], pb[2:0]};
				default: px = {pb[7], pb[5:3]};
			endcase
		end
		else
		begin
			src = (mode == mode_a_text) ? glyph : pb;
			dot = src[7 - i % 8];
			if (zxa && flash_on(p) && ab[7])
				dot = ~dot;
			px = dot ? {ab[6], ab[2:0]} : {(zxa ? ab[6] : ab[7]), ab[5:3]};
		end
	endtask

	always @(negedge clk)
	begin
		int         pc;
		int         off;
		logic [3:0] px;
		logic [7:0] code;
		if (active)
		begin
			pc = period_clocks();
			off = cyc % pc;
			compare_value("vram_rd", (off >= 1 && off <= 4), vram_rd);
			if (vram_rd)
			begin
				compare_value("vram_addr", fetch_addr(cyc / pc, off - 1), vram_addr);
				reads_in_period++;
			end
			if (off == 0 && cyc > 0)
			begin
				compare_value("vram reads per period", 4, reads_in_period);
				reads_in_period = 0;
			end
			compare_value("int_start", (off == 0 && (cyc / pc) % frame_periods == 0), int_start);
			compare_value("pix_stb", (cyc % 4 == 3 || (pixf_14 && cyc % 4 == 2)), pix_stb);
			if (int_start)
			begin
				if (starts_seen > 0)
					compare_value("pix_stb per frame", period_pixels() * frame_periods,
						stb_in_frame);
				stb_in_frame = 0;
				starts_seen++;
			end
			if (pix_stb)
			begin
				predict_pixel(pix_k, px, code);
				compare_value("pixels", px, pixels);
				if (store_seq)
					zx_seq.push_back(pixels);
				if (compare_seq && pix_k < zx_seq.size())
					compare_value("pixels vs first zx run", zx_seq[pix_k], pixels);
				if (mode == mode_a_text && pix_k % 8 == 7)
					glyph = rotate_left(code, text_row(pix_k / period_pixels())); // next cell
				pix_k++;
				stb_in_frame++;
			end
			cyc++;
		end
	end

	task automatic run_mode(input video_mode_e m, input logic fast, input int frames);
		@(posedge clk);
		#2;
		active = 1'b0;
		reset = 1'b1;
		mode = m;
		pixf_14 = fast;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;
		cyc = 0;
		pix_k = 0;
		reads_in_period = 0;
		stb_in_frame = 0;
		starts_seen = 0;
		glyph = 8'h00;
		active = 1'b1;
		while (starts_seen < frames + 1)
			@(posedge clk);
	endtask

	initial
	begin
		void'($urandom(32'hd0d));
		for (int a = 0; a < 65536; a++)
			vram[a] = 16'($urandom);
		store_seq = 1'b1;
		run_mode(mode_zx, 1'b0, long_frames);
		store_seq = 1'b0;
		run_mode(mode_p_16c, 1'b0, short_frames);
		run_mode(mode_a_16c, 1'b0, short_frames);
		run_mode(mode_a_text, 1'b0, short_frames);
		run_mode(mode_a_hmclr, 1'b0, long_frames); // flash frames reached, no inversion here
		compare_seq = 1'b1;
		run_mode(mode_zx, 1'b1, long_frames); // 14 MHz pixels
		$display("RESULT: PASS");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles == timeout_limit)
		begin
			$display("RESULT: FAIL");
			$fatal(1, "timeout after %0d cycles, the test runs did not finish", timeout_limit);
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
video_pkg.sv
video_sync.sv
video_fetch.sv
video_render.sv
video_fontrom.sv
video_top.sv
tb_video.sv

// File: Makefile
TOP = tb_video

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f filelist.f

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir
